// File: verilog/uart_pkg.sv
package uart_pkg;

	// ##################################################
	// serial line timing
	// ##################################################

	// clock cycles per serial bit, the line rate is fixed at build time
	localparam int CLOCKS_PER_BIT = 16;

	// offset from the start edge to the middle of a bit
	localparam int HALF_BIT = CLOCKS_PER_BIT / 2;

	// width of the per-bit cycle counter
	localparam int BIT_CNT_W = $clog2(CLOCKS_PER_BIT);

	// ##################################################
	// received byte
	// ##################################################

	// frame_err is set when the stop bit was sampled low
	typedef struct packed {
		logic [7:0] data;
		logic       frame_err;
	} rx_byte_t;

endpackage

// File: verilog/dbg_pkg.sv
package dbg_pkg;

	// ##################################################
	// command encoding and register map
	// ##################################################

	// bit 7 of a command byte selects a write, bits 3:0 hold the address
	localparam int CMD_WRITE_BIT = 7;

	localparam logic [3:0] REG_CTRL    = 4'd0;
	localparam logic [3:0] REG_BP_LO   = 4'd1;
	localparam logic [3:0] REG_BP_HI   = 4'd2;
	localparam logic [3:0] REG_STATUS  = 4'd3;
	localparam logic [3:0] REG_SCRATCH = 4'd4;

	// reply byte for an address with no register behind it
	localparam logic [7:0] DBG_ERR_CODE = 8'hEE;

	// CTRL bits, the step bit is self-clearing
	localparam int CTRL_HALT = 0;
	localparam int CTRL_STEP = 1;

	// STATUS bits, frame error and overrun are sticky
	localparam int STAT_HALTED    = 0;
	localparam int STAT_FRAME_ERR = 1;
	localparam int STAT_OVERRUN   = 2;

	// ##################################################
	// structs
	// ##################################################

	// control lines into the processor
	typedef struct packed {
		logic        halt;
		logic        step;
		logic [15:0] bp_addr;
	} dbg_ctrl_t;

	// one register access from the command engine
	typedef struct packed {
		logic       write;
		logic [3:0] addr;
		logic [7:0] wdata;
	} reg_req_t;

endpackage

// File: verilog/uart_line.sv
module uart_line (
	input  logic               iCLOCK,
	input  logic               inRESET,
	input  logic               tx_valid,
	input  logic [7:0]         tx_data,
	output logic               tx_ready,
	output logic               txd,
	input  logic               rxd,
	output logic               rx_valid,
	output uart_pkg::rx_byte_t rx_byte
);

	// ##################################################
	// transmitter
	// ##################################################

	logic                          tx_busy;
	logic [9:0]                    tx_shift;
	logic [3:0]                    tx_bit_idx;
	logic [uart_pkg::BIT_CNT_W-1:0] tx_clk_cnt;
	logic                          tx_bit_end;

	// the shift register idles at all ones, so its low bit is the line itself
	assign txd        = tx_shift[0];
	assign tx_ready   = !tx_busy;
	assign tx_bit_end = int'(tx_clk_cnt) == uart_pkg::CLOCKS_PER_BIT - 1;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tx_busy    <= 1'b0;
			tx_shift   <= '1;
			tx_bit_idx <= '0;
			tx_clk_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_valid) begin
				// stop, data LSB first, start in the low bit
				tx_busy    <= 1'b1;
				tx_shift   <= {1'b1, tx_data, 1'b0};
				tx_bit_idx <= '0;
				tx_clk_cnt <= '0;
			end
		end else if (tx_bit_end) begin
			tx_clk_cnt <= '0;
			tx_shift   <= {1'b1, tx_shift[9:1]};
			tx_bit_idx <= tx_bit_idx + 1'b1;
			// ready again once the stop bit has run its full period
			if (tx_bit_idx == 4'd9) begin
				tx_busy <= 1'b0;
			end
		end else begin
			tx_clk_cnt <= tx_clk_cnt + 1'b1;
		end
	end

	// ##################################################
	// receiver
	// ##################################################

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t                     rx_state;
	logic                          rxd_meta;
	logic                          rxd_sync;
	logic                          rxd_prev;
	logic [7:0]                    rx_shift;
	logic [2:0]                    rx_bit_idx;
	logic [uart_pkg::BIT_CNT_W-1:0] rx_clk_cnt;
	logic                          rx_mid_start;
	logic                          rx_mid_bit;

	assign rx_mid_start = int'(rx_clk_cnt) == uart_pkg::HALF_BIT - 1;
	assign rx_mid_bit   = int'(rx_clk_cnt) == uart_pkg::CLOCKS_PER_BIT - 1;

	// two flops against metastability, a third one for edge detection
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rx_state   <= RX_IDLE;
			rx_bit_idx <= '0;
			rx_clk_cnt <= '0;
			rx_valid   <= 1'b0;
		end else begin
			rx_valid   <= 1'b0;
			rx_clk_cnt <= rx_clk_cnt + 1'b1;
			case (rx_state)
				RX_IDLE: begin
					// the counter restarts on the falling start edge
					rx_clk_cnt <= '0;
					if (rxd_prev && !rxd_sync) begin
						rx_state <= RX_START;
					end
				end
				RX_START: begin
					if (rx_mid_start) begin
						rx_clk_cnt <= '0;
						rx_bit_idx <= '0;
						// a start bit that is gone by mid-bit was a glitch
						rx_state   <= rxd_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (rx_mid_bit) begin
						rx_clk_cnt <= '0;
						rx_bit_idx <= rx_bit_idx + 1'b1;
						if (rx_bit_idx == 3'd7) begin
							rx_state <= RX_STOP;
						end
					end
				end
				default: begin
					if (rx_mid_bit) begin
						rx_valid <= 1'b1;
						rx_state <= RX_IDLE;
					end
				end
			endcase
		end
	end

	// data bits arrive LSB first and shift in from the top
	always_ff @(posedge iCLOCK) begin
		if (rx_state == RX_DATA && rx_mid_bit) begin
			rx_shift <= {rxd_sync, rx_shift[7:1]};
		end
		if (rx_state == RX_STOP && rx_mid_bit) begin
			rx_byte.data      <= rx_shift;
			rx_byte.frame_err <= !rxd_sync;
		end
	end

endmodule

// File: verilog/sync_fifo.sv
module sync_fifo #(
	parameter type T     = logic [7:0],
	parameter int  DEPTH = 4
) (
	input  logic iCLOCK,
	input  logic inRESET,
	input  logic in_valid,
	input  T     in_data,
	output logic in_ready,
	output logic dropped,
	output logic out_valid,
	input  logic out_ready,
	output T     out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	T                 mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	assign in_ready  = int'(count) != DEPTH;
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;

	// a producer that cannot stall sees its item lost here
	assign dropped = in_valid && !in_ready;

	always_ff @(posedge iCLOCK) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// pointers wrap by compare so that depths other than powers of two work
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verilog/dbg_cmd_engine.sv
module dbg_cmd_engine (
	input  logic               iCLOCK,
	input  logic               inRESET,
	input  logic               rx_valid,
	input  uart_pkg::rx_byte_t rx_byte,
	output logic               rx_ready,
	output logic               req_valid,
	output dbg_pkg::reg_req_t  req,
	input  logic [7:0]         rdata,
	output logic               frame_err_set,
	output logic               reply_valid,
	input  logic               reply_ready,
	output logic [7:0]         reply_data
);

	typedef enum logic [1:0] {
		S_CMD,
		S_DATA,
		S_ACCESS,
		S_REPLY
	} state_t;

	state_t            state;
	dbg_pkg::reg_req_t cmd;
	logic              pop;
	logic              pop_good;

	// ##################################################
	// handshakes
	// ##################################################

	// bytes are only taken while a command is being collected, so a full
	// tx FIFO holds the engine in S_REPLY and the rx FIFO fills up behind it
	assign rx_ready = (state == S_CMD) || (state == S_DATA);
	assign pop      = rx_valid && rx_ready;
	assign pop_good = pop && !rx_byte.frame_err;

	// a corrupted byte is still popped, only its error is passed on
	assign frame_err_set = pop && rx_byte.frame_err;

	assign req_valid   = state == S_ACCESS;
	assign req         = cmd;
	assign reply_valid = state == S_REPLY;

	// ##################################################
	// FSM
	// ##################################################

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= S_CMD;
		end else begin
			case (state)
				S_CMD: begin
					if (pop_good) begin
						// reads go straight to the access, writes need a data byte
						if (rx_byte.data[dbg_pkg::CMD_WRITE_BIT]) begin
							state <= S_DATA;
						end else begin
							state <= S_ACCESS;
						end
					end
				end
				S_DATA: begin
					if (pop) begin
						// a bad data byte throws away the whole command
						state <= rx_byte.frame_err ? S_CMD : S_ACCESS;
					end
				end
				S_ACCESS: begin
					state <= S_REPLY;
				end
				default: begin
					if (reply_ready) begin
						state <= S_CMD;
					end
				end
			endcase
		end
	end

	// ##################################################
	// command and reply payload
	// ##################################################

	always_ff @(posedge iCLOCK) begin
		if (state == S_CMD && pop_good) begin
			cmd.write <= rx_byte.data[dbg_pkg::CMD_WRITE_BIT];
			cmd.addr  <= rx_byte.data[3:0];
			cmd.wdata <= '0;
		end
		if (state == S_DATA && pop_good) begin
			cmd.wdata <= rx_byte.data;
		end
		// rdata already shows the register after this access
		if (state == S_ACCESS) begin
			reply_data <= rdata;
		end
	end

endmodule

// File: verilog/dbg_regs.sv
module dbg_regs (
	input  logic               iCLOCK,
	input  logic               inRESET,
	input  logic               req_valid,
	input  dbg_pkg::reg_req_t  req,
	output logic [7:0]         rdata,
	input  logic               cpu_halted,
	input  logic               frame_err_set,
	input  logic               overrun_set,
	output dbg_pkg::dbg_ctrl_t ctrl
);

	logic       halt_q;
	logic       step_q;
	logic [7:0] bp_lo;
	logic [7:0] bp_hi;
	logic [7:0] scratch;
	logic       frame_err_q;
	logic       overrun_q;
	logic       wr;
	logic       status_clr;
	logic [7:0] ctrl_rd;
	logic [7:0] status_rd;

	assign wr         = req_valid && req.write;
	assign status_clr = req_valid && !req.write && req.addr == dbg_pkg::REG_STATUS;

	assign ctrl = '{halt: halt_q, step: step_q, bp_addr: {bp_hi, bp_lo}};

	// ##################################################
	// read side, showing the value after a write
	// ##################################################

	always_comb begin
		ctrl_rd = '0;
		ctrl_rd[dbg_pkg::CTRL_HALT] = wr ? req.wdata[dbg_pkg::CTRL_HALT] : halt_q;
		status_rd = '0;
		status_rd[dbg_pkg::STAT_HALTED]    = cpu_halted;
		status_rd[dbg_pkg::STAT_FRAME_ERR] = frame_err_q;
		status_rd[dbg_pkg::STAT_OVERRUN]   = overrun_q;
		case (req.addr)
			dbg_pkg::REG_CTRL:    rdata = ctrl_rd;
			dbg_pkg::REG_BP_LO:   rdata = wr ? req.wdata : bp_lo;
			dbg_pkg::REG_BP_HI:   rdata = wr ? req.wdata : bp_hi;
			dbg_pkg::REG_STATUS:  rdata = status_rd;
			dbg_pkg::REG_SCRATCH: rdata = wr ? req.wdata : scratch;
			default:              rdata = dbg_pkg::DBG_ERR_CODE;
		endcase
	end

	// ##################################################
	// register updates
	// ##################################################

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			halt_q      <= 1'b0;
			step_q      <= 1'b0;
			bp_lo       <= '0;
			bp_hi       <= '0;
			scratch     <= '0;
			frame_err_q <= 1'b0;
			overrun_q   <= 1'b0;
		end else begin
			// step is a single cycle pulse and never reads back as set
			step_q <= 1'b0;
			if (wr) begin
				case (req.addr)
					dbg_pkg::REG_CTRL: begin
						halt_q <= req.wdata[dbg_pkg::CTRL_HALT];
						step_q <= req.wdata[dbg_pkg::CTRL_STEP];
					end
					dbg_pkg::REG_BP_LO:   bp_lo <= req.wdata;
					dbg_pkg::REG_BP_HI:   bp_hi <= req.wdata;
					dbg_pkg::REG_SCRATCH: scratch <= req.wdata;
					default: begin
					end
				endcase
			end
			// a new error in the same cycle as the clear must not be lost
			frame_err_q <= frame_err_set || (frame_err_q && !status_clr);
			overrun_q   <= overrun_set || (overrun_q && !status_clr);
		end
	end

endmodule

// File: verilog/dbg_uart_top.sv
module dbg_uart_top (
	input  logic               iCLOCK,
	input  logic               inRESET,
	input  logic               rxd,
	output logic               txd,
	input  logic               cpu_halted,
	output dbg_pkg::dbg_ctrl_t ctrl
);

	logic               rx_valid;
	uart_pkg::rx_byte_t rx_byte;
	logic               rx_dropped;
	logic               cmd_valid;
	uart_pkg::rx_byte_t cmd_byte;
	logic               cmd_ready;
	logic               req_valid;
	dbg_pkg::reg_req_t  req;
	logic [7:0]         rdata;
	logic               frame_err_set;
	logic               reply_valid;
	logic               reply_ready;
	logic [7:0]         reply_data;
	logic               tx_valid;
	logic [7:0]         tx_data;
	logic               tx_ready;

	uart_line u_line (
		.iCLOCK, .inRESET,
		.tx_valid, .tx_data, .tx_ready, .txd,
		.rxd, .rx_valid, .rx_byte
	);

	// the receiver cannot wait, so a full FIFO drops and reports instead
	sync_fifo #(.T(uart_pkg::rx_byte_t), .DEPTH(4)) rx_fifo (
		.iCLOCK, .inRESET,
		.in_valid(rx_valid), .in_data(rx_byte), .in_ready(), .dropped(rx_dropped),
		.out_valid(cmd_valid), .out_ready(cmd_ready), .out_data(cmd_byte)
	);

	dbg_cmd_engine u_engine (
		.iCLOCK, .inRESET,
		.rx_valid(cmd_valid), .rx_byte(cmd_byte), .rx_ready(cmd_ready),
		.req_valid, .req, .rdata, .frame_err_set,
		.reply_valid, .reply_ready, .reply_data
	);

	dbg_regs u_regs (
		.iCLOCK, .inRESET,
		.req_valid, .req, .rdata, .cpu_halted,
		.frame_err_set, .overrun_set(rx_dropped), .ctrl
	);

	sync_fifo #(.T(logic [7:0]), .DEPTH(4)) tx_fifo (
		.iCLOCK, .inRESET,
		.in_valid(reply_valid), .in_data(reply_data), .in_ready(reply_ready), .dropped(),
		.out_valid(tx_valid), .out_ready(tx_ready), .out_data(tx_data)
	);

endmodule

// File: tb/dbg_uart_checker.sv
module dbg_uart_checker (
	input logic               iCLOCK,
	input logic               inRESET,
	input logic               txd,
	input logic               tx_ready,
	input dbg_pkg::dbg_ctrl_t ctrl,
	input logic               reply_valid,
	input logic               reply_ready,
	input logic [7:0]         reply_data
);

	// ##################################################
	// line and control outputs
	// ##################################################

	// an idle transmitter holds the line at the stop level
	idle_line_high: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) tx_ready |-> txd
	) else $error("txd is low while the transmitter is idle");

	// the step output is a single cycle pulse
	step_single_cycle: assert property (
		@(posedge iCLOCK) disable iff (!inRESET) ctrl.step |=> !ctrl.step
	) else $error("ctrl.step stayed high for more than one cycle");

	// ##################################################
	// reply path into the tx FIFO
	// ##################################################

	// while the tx FIFO is full the engine keeps its reply and pushes nothing new
	reply_held_when_full: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		reply_valid && !reply_ready |=> reply_valid && $stable(reply_data)
	) else $error("reply was not held while the tx FIFO was full");

endmodule

bind dbg_uart_top dbg_uart_checker u_checker (
	.iCLOCK, .inRESET, .txd, .tx_ready, .ctrl,
	.reply_valid, .reply_ready, .reply_data
);

// File: tb/tb_dbg_uart.sv
module tb_dbg_uart;

	localparam int CLK_PERIOD    = 8;
	localparam int BIT_CYCLES    = uart_pkg::CLOCKS_PER_BIT;
	localparam int FRAME_CYCLES  = 10 * BIT_CYCLES;
	localparam int NUM_ENTRIES   = 20;
	localparam int WATCHDOG_TIME = NUM_ENTRIES * 40 * FRAME_CYCLES * CLK_PERIOD;

	// one host command with everything the DUT should answer
	typedef struct packed {
		logic [7:0]  cmd;
		logic        has_data;
		logic [7:0]  data;
		logic        bad_stop;
		logic        halted;
		logic        wait_reply;
		logic        has_reply;
		logic [7:0]  reply;
		logic        exp_halt;
		logic [15:0] exp_bp;
		logic [7:0]  exp_steps;
	} entry_t;

	logic               iCLOCK;
	logic               inRESET;
	logic               rxd;
	logic               txd;
	logic               cpu_halted;
	dbg_pkg::dbg_ctrl_t ctrl;

	entry_t      stim [NUM_ENTRIES];
	int          n_entries;
	logic [31:0] seed;
	logic [7:0]  rx_q [$];
	logic [7:0]  exp_q [$];
	int          step_count;
	int          error_count;

	// register model used while the table is built
	logic        m_halt;
	logic [15:0] m_bp;
	logic [7:0]  m_scratch;
	logic        m_frame_err;
	logic [7:0]  m_steps;

	dbg_uart_top uut (
		.iCLOCK, .inRESET, .rxd, .txd, .cpu_halted, .ctrl
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	// ##################################################
	// helpers
	// ##################################################

	task automatic abort_run();
		error_count++;
		$display("** FAIL **");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output logic [7:0] value);
		seed  = lcg_next(seed);
		value = seed[23:16];
	endtask

	// serializes one byte onto rxd, called on a falling edge
	task automatic send_byte(input logic [7:0] value, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, value, 1'b0};
		for (int b = 0; b < 10; b++) begin
			rxd = frame[b];
			repeat (BIT_CYCLES) @(negedge iCLOCK);
		end
		// a low stop bit needs an idle period before the next start edge
		if (bad_stop) begin
			rxd = 1'b1;
			repeat (BIT_CYCLES) @(negedge iCLOCK);
		end
	endtask

	// appends one command and works out its reply from the register rules
	task automatic add_entry(input logic [7:0] cmd, input logic has_data,
			input logic [7:0] data, input logic bad_stop, input logic halted,
			input logic wait_reply);
		entry_t     e;
		logic       wr;
		logic [3:0] addr;
		e    = '0;
		wr   = cmd[dbg_pkg::CMD_WRITE_BIT];
		addr = cmd[3:0];
		e.cmd = cmd;
		e.has_data = has_data;
		e.data = data;
		e.bad_stop = bad_stop;
		e.halted = halted;
		e.wait_reply = wait_reply;
		e.has_reply = !bad_stop;
		if (bad_stop) begin
			m_frame_err = 1'b1;
		end else begin
			case (addr)
				dbg_pkg::REG_CTRL: begin
					if (wr) begin
						m_halt = data[dbg_pkg::CTRL_HALT];
						if (data[dbg_pkg::CTRL_STEP]) m_steps++;
					end
					e.reply = {7'd0, m_halt};
				end
				dbg_pkg::REG_BP_LO: begin
					if (wr) m_bp[7:0] = data;
					e.reply = m_bp[7:0];
				end
				dbg_pkg::REG_BP_HI: begin
					if (wr) m_bp[15:8] = data;
					e.reply = m_bp[15:8];
				end
				dbg_pkg::REG_STATUS: begin
					e.reply = {5'd0, 1'b0, m_frame_err, halted};
					if (!wr) m_frame_err = 1'b0;
				end
				dbg_pkg::REG_SCRATCH: begin
					if (wr) m_scratch = data;
					e.reply = m_scratch;
				end
				default: e.reply = dbg_pkg::DBG_ERR_CODE;
			endcase
		end
		e.exp_halt  = m_halt;
		e.exp_bp    = m_bp;
		e.exp_steps = m_steps;
		stim[n_entries] = e;
		n_entries++;
	endtask

	task automatic build_table();
		logic [7:0] scr_a;
		logic [7:0] scr_b;
		logic [7:0] bp_lo;
		logic [7:0] bp_hi;
		logic [7:0] junk;
		next_random(scr_a);
		next_random(scr_b);
		next_random(bp_lo);
		next_random(bp_hi);
		next_random(junk);
		add_entry({4'h8, dbg_pkg::REG_SCRATCH}, 1'b1, scr_a, 1'b0, 1'b0, 1'b1);
		add_entry({4'h8, dbg_pkg::REG_SCRATCH}, 1'b1, scr_b, 1'b0, 1'b0, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_SCRATCH}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		add_entry({4'h8, dbg_pkg::REG_CTRL}, 1'b1, 8'h01, 1'b0, 1'b0, 1'b1);
		add_entry({4'h8, dbg_pkg::REG_CTRL}, 1'b1, 8'h03, 1'b0, 1'b0, 1'b1);
		add_entry({4'h8, dbg_pkg::REG_CTRL}, 1'b1, 8'h02, 1'b0, 1'b0, 1'b1);
		add_entry({4'h8, dbg_pkg::REG_BP_LO}, 1'b1, bp_lo, 1'b0, 1'b0, 1'b1);
		add_entry({4'h8, dbg_pkg::REG_BP_HI}, 1'b1, bp_hi, 1'b0, 1'b0, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_BP_LO}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_STATUS}, 1'b0, 8'h00, 1'b0, 1'b1, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_STATUS}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		add_entry(8'h07, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		add_entry(8'h89, 1'b1, junk, 1'b0, 1'b0, 1'b1);
		// corrupted command frame, then STATUS shows and clears the error
		add_entry({4'h0, dbg_pkg::REG_SCRATCH}, 1'b0, 8'h00, 1'b1, 1'b0, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_STATUS}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_STATUS}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		// three reads with no idle time between the frames
		add_entry({4'h0, dbg_pkg::REG_SCRATCH}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
		add_entry({4'h0, dbg_pkg::REG_BP_HI}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b0);
		add_entry({4'h0, dbg_pkg::REG_CTRL}, 1'b0, 8'h00, 1'b0, 1'b0, 1'b1);
		add_entry({4'h0, dbg_pkg::REG_STATUS}, 1'b0, 8'h00, 1'b0, 1'b1, 1'b1);
	endtask

	task automatic check_ctrl(input entry_t e);
		assert (ctrl.halt == e.exp_halt) else begin
			$display("Fail at %0t: ctrl.halt = %0b, expected %0b", $time, ctrl.halt, e.exp_halt);
			abort_run();
		end
		assert (ctrl.bp_addr == e.exp_bp) else begin
			$display("Fail at %0t: ctrl.bp_addr = 16'h%04h, expected 16'h%04h",
				$time, ctrl.bp_addr, e.exp_bp);
			abort_run();
		end
		assert (step_count == int'(e.exp_steps)) else begin
			$display("Fail at %0t: step pulses = %0d, expected %0d",
				$time, step_count, e.exp_steps);
			abort_run();
		end
	endtask

	// ##################################################
	// monitors and watchdog
	// ##################################################

	// decodes reply frames on txd at mid-bit
	initial begin : txd_monitor
		logic [7:0] value;
		forever begin
			@(negedge iCLOCK);
			if (inRESET && txd == 1'b0) begin
				repeat (BIT_CYCLES / 2) @(negedge iCLOCK);
				assert (txd == 1'b0) else begin
					$display("start bit of a reply frame did not last to mid-bit");
					abort_run();
				end
				for (int b = 0; b < 8; b++) begin
					repeat (BIT_CYCLES) @(negedge iCLOCK);
					value[b] = txd;
				end
				repeat (BIT_CYCLES) @(negedge iCLOCK);
				assert (txd == 1'b1) else begin
					$display("stop bit of a reply frame was low");
					abort_run();
				end
				rx_q.push_back(value);
			end
		end
	end

	initial begin : step_counter
		step_count = 0;
		forever begin
			@(negedge iCLOCK);
			if (ctrl.step) step_count++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_TIME);
		$display("timeout: the tests did not finish within %0d time units", WATCHDOG_TIME);
		abort_run();
	end

	// ##################################################
	// main sequence
	// ##################################################

	initial begin : main
		entry_t     e;
		logic [7:0] got;
		logic [7:0] want;
		inRESET = 1'b0;
		rxd = 1'b1;
		cpu_halted = 1'b0;
		error_count = 0;
		n_entries = 0;
		seed = 32'hd92e_b76a;
		m_halt = 1'b0;
		m_bp = '0;
		m_scratch = '0;
		m_frame_err = 1'b0;
		m_steps = '0;
		build_table();
		assert (n_entries == NUM_ENTRIES) else begin
			$display("the stimulus table holds %0d entries instead of %0d",
				n_entries, NUM_ENTRIES);
			abort_run();
		end
		repeat (10) @(negedge iCLOCK);
		inRESET = 1'b1;
		repeat (4) @(negedge iCLOCK);
		assert (txd == 1'b1 && ctrl == '0) else begin
			$display("Fail at %0t: txd = %0b ctrl = %h, expected 1 and 0", $time, txd, ctrl);
			abort_run();
		end
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			e = stim[i];
			cpu_halted = e.halted;
			send_byte(e.cmd, e.bad_stop);
			if (e.has_data) send_byte(e.data, 1'b0);
			if (e.has_reply) exp_q.push_back(e.reply);
			if (e.wait_reply) begin
				// a dropped frame must stay silent for a while
				if (!e.has_reply) repeat (3 * FRAME_CYCLES) @(negedge iCLOCK);
				while (rx_q.size() < exp_q.size()) @(negedge iCLOCK);
				while (exp_q.size() > 0) begin
					got  = rx_q.pop_front();
					want = exp_q.pop_front();
					assert (got == want) else begin
						$display("Fail at %0t: reply = 8'h%02h, expected 8'h%02h (entry %0d)",
							$time, got, want, i);
						abort_run();
					end
				end
				assert (rx_q.size() == 0) else begin
					$display("a reply arrived that no command asked for (entry %0d)", i);
					abort_run();
				end
				check_ctrl(e);
			end
		end
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: vlog.f
verilog/uart_pkg.sv
verilog/dbg_pkg.sv
verilog/uart_line.sv
verilog/sync_fifo.sv
verilog/dbg_cmd_engine.sv
verilog/dbg_regs.sv
verilog/dbg_uart_top.sv
tb/dbg_uart_checker.sv
tb/tb_dbg_uart.sv

// File: run.sh
#!/bin/bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dbg_uart \
	-f vlog.f -o sim_dbg_uart > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_dbg_uart > sim.log 2>&1
cat sim.log

! grep -q -F '** FAIL **' sim.log && grep -q -F '** PASS **' sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
